/* sim/tb_fcs_model.svh */
/*
 * Reference model for the FCS inserter testbench, included inside
 * the testbench module. ref_crc32 is a bit-serial Ethernet CRC-32,
 * queue_frame turns one payload into the output beats the DUT must
 * produce and appends them to the expected-beat queues.
 */
`ifndef TB_FCS_MODEL_SVH
`define TB_FCS_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// expected output beats, oldest first
logic [63:0] exp_data[$];
logic [7:0]  exp_keep[$];
logic        exp_last[$];
logic        exp_user[$];

// reflected, init all ones, result complemented
function automatic logic [31:0] ref_crc32(input byte_q_t data_in);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hFFFF_FFFF;
    foreach (data_in[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ data_in[i][b];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
    end
    return ~crc;
endfunction

// output stream packed eight bytes per beat, FCS LSB first
task automatic queue_frame(input byte_q_t payload, input bit err);
    byte_q_t     stream;
    logic [31:0] fcs;
    logic [63:0] d;
    logic [7:0]  kp;
    int          nbeats;
    stream = payload;
    if (!err) begin
        fcs = ref_crc32(payload);
        for (int i = 0; i < 4; i++) begin
            stream.push_back(fcs[i*8 +: 8]);
        end
    end
    nbeats = (stream.size() + 7) / 8;
    for (int b = 0; b < nbeats; b++) begin
        d  = '0;
        kp = '0;
        for (int i = 0; i < 8; i++) begin
            if (b * 8 + i < stream.size()) begin
                d[i*8 +: 8] = stream[b*8 + i];
                kp[i]       = 1'b1;
            end
        end
        exp_data.push_back(d);
        exp_keep.push_back(kp);
        exp_last.push_back(b == nbeats - 1);
        exp_user.push_back(err && (b == nbeats - 1));
    end
endtask

`endif

/* sim/tb_eth_fcs_insert.sv */
/*
 * Testbench for the 64-bit Ethernet FCS inserter. Sends good frames
 * covering every last-beat size, errored frames, and a mixed run under
 * random back-pressure and input gaps. Unkept input lanes always carry
 * random bytes. Output beats are compared with the reference model.
 */
`timescale 1ns/100ps

module tb_eth_fcs_insert;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 500;

    logic        clk;
    logic        rst;
    logic [63:0] in_data;
    logic [7:0]  in_keep;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic        in_user;
    logic [63:0] out_data;
    logic [7:0]  out_keep;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;
    logic        out_user;

    logic  rst_q = 1'b0;
    bit    bp_mode = 1'b0;
    int    check_errors = 0;
    int    timeout_errors = 0;
    string test_name = "reset";

    `include "tb_fcs_model.svh"

    eth_fcs_insert dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_user  (out_user)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random sink stall in back-pressure mode
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #0.5;
            out_ready = bp_mode ? ($urandom_range(0, 9) < 6) : 1'b1;
        end
    end

    always @(posedge clk) begin
        rst_q <= rst;
    end

    task automatic report_mismatch(input string what, input logic [63:0] expv,
                                   input logic [63:0] actv);
        check_errors++;
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expv, actv);
    endtask

    // quiet outputs during reset and one cycle after
    assert property (@(posedge clk) rst_q |-> (!in_ready && !out_valid))
        else report_mismatch("reset_outputs", 64'd0, $sampled({in_ready, out_valid}));

    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_keep)
                                       && $stable(out_last) && $stable(out_user)))
        else begin
            check_errors++;
            $display("held output beat changed while out_ready was low at %0t", $time);
        end

    task automatic check_beat(input logic [63:0] d, input logic [7:0] kp,
                              input logic l, input logic u);
        logic [63:0] mask;
        logic [63:0] exp_d;
        logic [7:0]  exp_k;
        logic        exp_l;
        logic        exp_u;
        if (exp_data.size() == 0) begin
            check_errors++;
            $display("output beat at %0t with no expected beat left (%s)", $time, test_name);
        end else begin
            exp_d = exp_data.pop_front();
            exp_k = exp_keep.pop_front();
            exp_l = exp_last.pop_front();
            exp_u = exp_user.pop_front();
            for (int i = 0; i < 8; i++) begin
                mask[i*8 +: 8] = {8{exp_k[i]}};
            end
            assert ((d & mask) === exp_d) else report_mismatch("data", exp_d, d & mask);
            assert (kp === exp_k) else report_mismatch("keep", exp_k, kp);
            assert (l === exp_l) else report_mismatch("last", exp_l, l);
            assert (u === exp_u) else report_mismatch("user", exp_u, u);
        end
    endtask

    // sampled mid-cycle, the transfer happens at the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid === 1'b1 && out_ready) begin
            check_beat(out_data, out_keep, out_last, out_user);
        end
    end

    function automatic byte_q_t make_payload(input int len);
        byte_q_t q;
        for (int i = 0; i < len; i++) begin
            q.push_back(8'($urandom));
        end
        return q;
    endfunction

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic wait_accept(output bit ok);
        int waited;
        ok     = 1'b0;
        waited = 0;
        while (!ok && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            ok = (in_ready === 1'b1);
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (!ok) begin
            timeout_errors++;
            $display("timeout: input beat not accepted within %0d cycles at %0t",
                     ACCEPT_LIMIT, $time);
        end
    endtask

    task automatic send_frame(input byte_q_t payload, input bit err);
        int          nbeats;
        int          k;
        bit          ok;
        logic [63:0] d;
        logic [7:0]  kp;
        nbeats = (payload.size() + 7) / 8;
        k      = payload.size() - 8 * (nbeats - 1);
        ok     = 1'b1;
        queue_frame(payload, err);
        for (int b = 0; b < nbeats && ok; b++) begin
            if (bp_mode) begin
                idle_cycles($urandom_range(0, 2));
            end
            // garbage in the lanes outside keep
            d  = {$urandom, $urandom};
            kp = '0;
            for (int i = 0; i < 8; i++) begin
                if (b * 8 + i < payload.size()) begin
                    d[i*8 +: 8] = payload[b*8 + i];
                    kp[i]       = 1'b1;
                end
            end
            in_data  = d;
            in_keep  = kp;
            in_last  = (b == nbeats - 1);
            in_user  = err && (b == nbeats - 1);
            in_valid = 1'b1;
            wait_accept(ok);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_user  = 1'b0;
        // FCS spills into an extra beat, input must stall
        if (ok && !err && k > 4) begin
            @(negedge clk);
            assert (in_ready === 1'b0) else report_mismatch("spill_stall", 64'd0, in_ready);
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d expected output beats never arrived (%s)",
                     exp_data.size(), test_name);
        end
        @(posedge clk);
        #0.5;
    endtask

    initial begin
        byte_q_t payload;
        int      len;
        bit      err;
        void'($urandom(23));
        rst      = 1'b1;
        in_data  = '0;
        in_keep  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_user  = 1'b0;
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;
        idle_cycles(3);

        // every last-beat size, lengths up to 40 bytes
        test_name = "good";
        for (int k = 1; k <= 8; k++) begin
            for (int r = 0; r < 2; r++) begin
                payload = make_payload(8 * $urandom_range(0, 4) + k);
                send_frame(payload, 1'b0);
            end
        end
        wait_drain();

        test_name = "error";
        for (int n = 0; n < 6; n++) begin
            payload = make_payload($urandom_range(1, 40));
            send_frame(payload, 1'b1);
        end
        wait_drain();

        test_name = "backpressure";
        bp_mode   = 1'b1;
        for (int n = 0; n < 30; n++) begin
            len     = $urandom_range(1, 40);
            err     = ($urandom_range(0, 4) == 0);
            payload = make_payload(len);
            send_frame(payload, err);
        end
        wait_drain();
        bp_mode = 1'b0;
        idle_cycles(4);

        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/axis_beat_if.sv */
/*
 * Stream beat bundle between the frame controller and the output
 * skid buffer. The source offers a beat every cycle, the sink takes
 * whatever is presented while ready is high. ready_early is the
 * value ready will have in the next cycle.
 */
`timescale 1ns/100ps

interface axis_beat_if;

    fcs_pkg::data_t data;
    fcs_pkg::keep_t keep;
    logic           valid;
    logic           last;
    logic           user;
    logic           ready;
    logic           ready_early;

    modport source (
        output data, keep, valid, last, user,
        input  ready, ready_early
    );

    modport sink (
        input  data, keep, valid, last, user,
        output ready, ready_early
    );

endinterface

/* verilog/crc32_lanes.sv */
/*
 * Running Ethernet CRC-32 over 64-bit beats. Produces the CRC for
 * every prefix length of the current beat so the splice logic can
 * pick the one matching the keep mask of the last beat.
 * crc_step absorbs the full beat, crc_clear restarts the frame.
 */
`timescale 1ns/100ps
`include "fcs_defs.svh"

module crc32_lanes (
    input  logic                clk,
    input  logic                rst,
    input  fcs_pkg::data_t      data,
    input  logic                crc_clear,
    input  logic                crc_step,
    output fcs_pkg::crc_lanes_t candidates
);

    fcs_pkg::crc_t crc_reg;

    // one byte through the reflected LFSR, LSB first
    function automatic fcs_pkg::crc_t crc_byte(
        input fcs_pkg::crc_t          crc_in,
        input logic [`FCS_BYTE_W-1:0] byte_in
    );
        fcs_pkg::crc_t c;
        c = crc_in;
        c[`FCS_BYTE_W-1:0] = c[`FCS_BYTE_W-1:0] ^ byte_in;
        for (int i = 0; i < `FCS_BYTE_W; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `FCS_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // chain of byte steps, one tap per prefix length
    always_comb begin
        fcs_pkg::crc_t acc;
        acc = crc_reg;
        for (int n = 0; n < `FCS_LANES; n++) begin
            acc = crc_byte(acc, data[n*`FCS_BYTE_W +: `FCS_BYTE_W]);
            candidates[n] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc_reg <= `FCS_CRC_INIT;
        end else if (crc_step) begin
            crc_reg <= candidates[`FCS_LANES-1];
        end
    end

endmodule

/* verilog/eth_fcs_insert.sv */
/*
 * 64-bit AXI-Stream Ethernet FCS inserter, top level.
 * Appends the CRC-32 FCS after the last payload byte of each good
 * frame; frames ending with in_user set pass through unchanged
 * with out_user set. Plain stream ports on both sides.
 */
`timescale 1ns/100ps

module eth_fcs_insert (
    input  logic           clk,
    input  logic           rst,
    input  fcs_pkg::data_t in_data,
    input  fcs_pkg::keep_t in_keep,
    input  logic           in_valid,
    output logic           in_ready,
    input  logic           in_last,
    input  logic           in_user,
    output fcs_pkg::data_t out_data,
    output fcs_pkg::keep_t out_keep,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           out_last,
    output logic           out_user
);

    fcs_pkg::data_t      beat_data;
    logic                crc_clear;
    logic                crc_step;
    fcs_pkg::crc_lanes_t candidates;
    fcs_pkg::data_t      tail_data;
    fcs_pkg::keep_t      tail_keep;
    fcs_pkg::data_t      spill_data;
    fcs_pkg::keep_t      spill_keep;

    axis_beat_if beat_if ();

    frame_ctrl ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_user    (in_user),
        .in_ready   (in_ready),
        .tail_data  (tail_data),
        .tail_keep  (tail_keep),
        .spill_data (spill_data),
        .spill_keep (spill_keep),
        .beat_data  (beat_data),
        .crc_clear  (crc_clear),
        .crc_step   (crc_step),
        .beat       (beat_if.source)
    );

    crc32_lanes crc (
        .clk        (clk),
        .rst        (rst),
        .data       (beat_data),
        .crc_clear  (crc_clear),
        .crc_step   (crc_step),
        .candidates (candidates)
    );

    fcs_splice splice (
        .data       (beat_data),
        .keep       (in_keep),
        .candidates (candidates),
        .tail_data  (tail_data),
        .tail_keep  (tail_keep),
        .spill_data (spill_data),
        .spill_keep (spill_keep)
    );

    out_skid_buffer skid (
        .clk       (clk),
        .rst       (rst),
        .beat      (beat_if.sink),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_user  (out_user),
        .out_ready (out_ready)
    );

endmodule

/* verilog/fcs_defs.svh */
/*
 * Fixed dimensions and CRC constants of the 64-bit FCS inserter.
 * Include this header wherever lane count, byte width or the
 * Ethernet CRC-32 constants are needed.
 */
`ifndef FCS_DEFS_SVH
`define FCS_DEFS_SVH

// byte lanes per beat
`define FCS_LANES 8

// bits per lane
`define FCS_BYTE_W 8

// Ethernet CRC-32, bit-reversed form for LSB-first processing
`define FCS_CRC_POLY 32'hEDB88320

`define FCS_CRC_INIT 32'hFFFFFFFF

`endif

/* verilog/fcs_pkg.sv */
/*
 * Datapath types and the frame state encoding shared by the
 * FCS inserter modules. Reference them by scoped name.
 */
`include "fcs_defs.svh"

package fcs_pkg;

    typedef logic [`FCS_LANES*`FCS_BYTE_W-1:0] data_t;

    typedef logic [`FCS_LANES-1:0] keep_t;

    typedef logic [31:0] crc_t;

    // entry n holds the CRC after the first n+1 bytes of a beat
    typedef crc_t [`FCS_LANES-1:0] crc_lanes_t;

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_PAYLOAD,
        FRAME_FCS
    } frame_state_t;

endpackage

/* verilog/fcs_splice.sv */
/*
 * Combinational merge of the last payload beat with its FCS.
 * The complemented CRC goes LSB first right after the last kept
 * byte; whatever does not fit lands in the spill beat. An all-zero
 * spill_keep means the frame ends in the tail beat.
 * Expects data with unkept lanes already zeroed.
 */
`timescale 1ns/100ps
`include "fcs_defs.svh"

module fcs_splice (
    input  fcs_pkg::data_t      data,
    input  fcs_pkg::keep_t      keep,
    input  fcs_pkg::crc_lanes_t candidates,
    output fcs_pkg::data_t      tail_data,
    output fcs_pkg::keep_t      tail_keep,
    output fcs_pkg::data_t      spill_data,
    output fcs_pkg::keep_t      spill_keep
);

    localparam int BEAT_W    = `FCS_LANES * `FCS_BYTE_W;
    localparam int CRC_W     = $bits(fcs_pkg::crc_t);
    localparam int FCS_BYTES = CRC_W / `FCS_BYTE_W;
    localparam int CNT_W     = $clog2(`FCS_LANES + 1);

    logic [CNT_W-1:0]         byte_cnt;
    fcs_pkg::crc_t            fcs;
    logic [2*BEAT_W-1:0]      fcs_wide;
    logic [2*BEAT_W-1:0]      wide_data;
    logic [2*`FCS_LANES-1:0]  wide_keep;

    // keep is contiguous from lane 0
    always_comb begin
        byte_cnt = '0;
        for (int i = 0; i < `FCS_LANES; i++) begin
            byte_cnt = byte_cnt + CNT_W'(keep[i]);
        end
    end

    always_comb begin
        fcs_wide = '0;
        if (byte_cnt == '0) begin
            // empty beat, nothing to attach
            fcs = '0;
            wide_data = {{BEAT_W{1'b0}}, data};
            wide_keep = {{`FCS_LANES{1'b0}}, keep};
        end else begin
            fcs = ~candidates[byte_cnt - 1'b1];
            fcs_wide[CRC_W-1:0] = fcs;
            wide_data = {{BEAT_W{1'b0}}, data} | (fcs_wide << (byte_cnt * `FCS_BYTE_W));
            wide_keep = {{`FCS_LANES{1'b0}}, keep}
                      | ({{(2*`FCS_LANES-FCS_BYTES){1'b0}}, {FCS_BYTES{1'b1}}} << byte_cnt);
        end
    end

    assign tail_data  = wide_data[BEAT_W-1:0];
    assign tail_keep  = wide_keep[`FCS_LANES-1:0];
    assign spill_data = wide_data[2*BEAT_W-1:BEAT_W];
    assign spill_keep = wide_keep[2*`FCS_LANES-1:`FCS_LANES];

endmodule

/* verilog/frame_ctrl.sv */
/*
 * Frame sequencing for the FCS inserter. Zeroes unkept input lanes,
 * steers the CRC register, and picks each beat offered downstream:
 * payload, tail with FCS, error pass-through or the spill beat.
 * in_ready is registered and follows the skid buffer's ready_early,
 * except while a spill beat is pending.
 */
`timescale 1ns/100ps
`include "fcs_defs.svh"

module frame_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  fcs_pkg::data_t     in_data,
    input  fcs_pkg::keep_t     in_keep,
    input  logic               in_valid,
    input  logic               in_last,
    input  logic               in_user,
    output logic               in_ready,
    input  fcs_pkg::data_t     tail_data,
    input  fcs_pkg::keep_t     tail_keep,
    input  fcs_pkg::data_t     spill_data,
    input  fcs_pkg::keep_t     spill_keep,
    output fcs_pkg::data_t     beat_data,
    output logic               crc_clear,
    output logic               crc_step,
    axis_beat_if.source        beat
);

    fcs_pkg::frame_state_t state, state_next;

    logic           in_ready_reg, in_ready_next;
    logic           accept;
    logic           spill_load;
    fcs_pkg::data_t spill_data_reg;
    fcs_pkg::keep_t spill_keep_reg;

    assign in_ready = in_ready_reg;
    assign accept   = in_valid & in_ready_reg;

    // zero the lanes outside keep
    always_comb begin
        for (int i = 0; i < `FCS_LANES; i++) begin
            beat_data[i*`FCS_BYTE_W +: `FCS_BYTE_W] =
                in_keep[i] ? in_data[i*`FCS_BYTE_W +: `FCS_BYTE_W] : '0;
        end
    end

    always_comb begin
        state_next    = state;
        in_ready_next = beat.ready_early;
        crc_clear     = 1'b0;
        crc_step      = 1'b0;
        spill_load    = 1'b0;

        beat.data  = beat_data;
        beat.keep  = in_keep;
        beat.valid = accept;
        beat.last  = 1'b0;
        beat.user  = 1'b0;

        case (state)
            fcs_pkg::FRAME_IDLE, fcs_pkg::FRAME_PAYLOAD: begin
                // hold the CRC at its start value between frames
                crc_clear = (state == fcs_pkg::FRAME_IDLE);
                if (accept) begin
                    crc_clear  = 1'b0;
                    crc_step   = 1'b1;
                    state_next = fcs_pkg::FRAME_PAYLOAD;
                    if (in_last) begin
                        crc_clear  = 1'b1;
                        crc_step   = 1'b0;
                        beat.last  = 1'b1;
                        state_next = fcs_pkg::FRAME_IDLE;
                        if (in_user) begin
                            // errored frame goes out as is
                            beat.user = 1'b1;
                        end else begin
                            beat.data  = tail_data;
                            beat.keep  = tail_keep;
                            spill_load = 1'b1;
                            if (spill_keep != '0) begin
                                beat.last     = 1'b0;
                                in_ready_next = 1'b0;
                                state_next    = fcs_pkg::FRAME_FCS;
                            end
                        end
                    end
                end
            end
            fcs_pkg::FRAME_FCS: begin
                in_ready_next = 1'b0;
                beat.data     = spill_data_reg;
                beat.keep     = spill_keep_reg;
                beat.valid    = 1'b1;
                beat.last     = 1'b1;
                if (beat.ready) begin
                    in_ready_next = beat.ready_early;
                    state_next    = fcs_pkg::FRAME_IDLE;
                end
            end
            default: begin
                state_next = fcs_pkg::FRAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= fcs_pkg::FRAME_IDLE;
            in_ready_reg <= 1'b0;
        end else begin
            state        <= state_next;
            in_ready_reg <= in_ready_next;
        end
    end

    // leftover FCS bytes for the extra beat
    always_ff @(posedge clk) begin
        if (spill_load) begin
            spill_data_reg <= spill_data;
            spill_keep_reg <= spill_keep;
        end
    end

endmodule

/* verilog/out_skid_buffer.sv */
/*
 * Two-slot output register for the FCS inserter. A beat offered
 * while ready is high lands in the output register, or in the
 * temporary slot if the output is stalled. ready is registered,
 * ready_early gives its next value to the upstream controller.
 */
`timescale 1ns/100ps

module out_skid_buffer (
    input  logic           clk,
    input  logic           rst,
    axis_beat_if.sink      beat,
    output fcs_pkg::data_t out_data,
    output fcs_pkg::keep_t out_keep,
    output logic           out_valid,
    output logic           out_last,
    output logic           out_user,
    input  logic           out_ready
);

    logic           ready_reg;
    logic           out_valid_next;
    logic           temp_valid, temp_valid_next;
    fcs_pkg::data_t temp_data;
    fcs_pkg::keep_t temp_keep;
    logic           temp_last;
    logic           temp_user;
    logic           store_in_to_out;
    logic           store_in_to_temp;
    logic           store_temp_to_out;

    assign beat.ready = ready_reg;
    // ok to accept next cycle unless the temp slot might fill
    assign beat.ready_early = out_ready | (~temp_valid & (~out_valid | ~beat.valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (out_ready || !out_valid) begin
                out_valid_next  = beat.valid;
                store_in_to_out = 1'b1;
            end else begin
                temp_valid_next  = beat.valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain the temp slot
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg  <= beat.ready_early;
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data <= beat.data;
            out_keep <= beat.keep;
            out_last <= beat.last;
            out_user <= beat.user;
        end else if (store_temp_to_out) begin
            out_data <= temp_data;
            out_keep <= temp_keep;
            out_last <= temp_last;
            out_user <= temp_user;
        end
        if (store_in_to_temp) begin
            temp_data <= beat.data;
            temp_keep <= beat.keep;
            temp_last <= beat.last;
            temp_user <= beat.user;
        end
    end

endmodule

/* vlog.f */
+incdir+verilog
+incdir+sim
verilog/fcs_pkg.sv
verilog/axis_beat_if.sv
verilog/crc32_lanes.sv
verilog/fcs_splice.sv
verilog/frame_ctrl.sv
verilog/out_skid_buffer.sv
verilog/eth_fcs_insert.sv
sim/tb_eth_fcs_insert.sv
